/* filelist.f */
+incdir+test
hdl/mcu_ctrl_pkg.sv
hdl/power_domain_fsm.sv
hdl/power_manager.sv
hdl/fast_irq_ctrl.sv
hdl/mcu_ctrl_top.sv
test/tb_mcu_ctrl.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the MCU control testbench with Verilator.
# The exit status is the simulator's: nonzero when the testbench fails.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f filelist.f --top-module tb_mcu_ctrl -Mdir obj_dir \
  && ./obj_dir/Vtb_mcu_ctrl \
  || { echo "simulation failed"; exit 1; }

/* test/tb_mcu_ctrl_ref.svh */
// Reference model for the MCU control testbench
// expected domain controls and interrupt word, plus typed compare tasks
`ifndef TB_MCU_CTRL_REF_SVH
`define TB_MCU_CTRL_REF_SVH

function automatic pwr_ctrl_out_t powered_state();
  pwr_ctrl_out_t s;
  s.pwrgate_en_n   = 1'b0;
  s.isogate_en_n   = 1'b1;
  s.rst_n          = 1'b1;
  s.clkgate_en_n   = 1'b1;
  s.retentive_en_n = 1'b1;
  return s;
endfunction

// final controls of a domain after one command
function automatic pwr_ctrl_out_t next_ctrl(input pwr_ctrl_out_t prev, input pwr_op_e op);
  pwr_ctrl_out_t nxt;
  logic          switched_off;
  switched_off = prev.pwrgate_en_n;
  nxt = prev;
  if (op == PWR_ON) begin
    nxt = powered_state();
  end else if (!switched_off && op == PWR_OFF) begin
    nxt.clkgate_en_n = 1'b0;
    nxt.isogate_en_n = 1'b0;
    nxt.rst_n        = 1'b0;
    nxt.pwrgate_en_n = 1'b1;
  end else if (!switched_off) begin
    nxt.clkgate_en_n   = 1'b0;
    nxt.retentive_en_n = 1'b0;
  end
  return nxt;
endfunction

// set has priority over the acknowledge clear
function automatic logic [NUM_FAST_IRQ-1:0] next_pending(
  input logic [NUM_FAST_IRQ-1:0] pend,
  input fast_irq_src_t           src,
  input logic                    ack,
  input logic [IRQ_ID_W-1:0]     id
);
  logic [NUM_FAST_IRQ-1:0] nxt;
  logic [NUM_FAST_IRQ-1:0] src_bits;
  src_bits = src;
  for (int i = 0; i < NUM_FAST_IRQ; i++) begin
    if (src_bits[i]) begin
      nxt[i] = 1'b1;
    end else if (ack && int'(id) == FAST_IRQ_BASE + i) begin
      nxt[i] = 1'b0;
    end else begin
      nxt[i] = pend[i];
    end
  end
  return nxt;
endfunction

function automatic logic [IRQ_W-1:0] expected_irq(
  input logic [NUM_FAST_IRQ-1:0] pend,
  input logic                    sw,
  input logic                    tmr,
  input logic                    ext
);
  logic [IRQ_W-1:0] word;
  word = '0;
  word[IRQ_SOFTWARE_BIT] = sw;
  word[IRQ_TIMER_BIT]    = tmr;
  word[IRQ_EXTERNAL_BIT] = ext;
  for (int i = 0; i < NUM_FAST_IRQ; i++) begin
    word[FAST_IRQ_BASE + i] = pend[i];
  end
  return word;
endfunction

task automatic check_pwr_ctrl(input int dom, input pwr_ctrl_out_t got,
                              input pwr_ctrl_out_t exp);
  if (got !== exp) begin
    $display("Error: pwr_ctrl_o[%0d] = 0x%h, expected 0x%h", dom, got, exp);
    fail_run();
  end
endtask

task automatic check_irq(input logic [IRQ_W-1:0] got, input logic [IRQ_W-1:0] exp);
  if (got !== exp) begin
    $display("Error: irq_o = 0x%h, expected 0x%h", got, exp);
    fail_run();
  end
endtask

task automatic check_rst(input logic [NUM_DOMAINS-1:0] got,
                         input logic [NUM_DOMAINS-1:0] exp);
  if (got !== exp) begin
    $display("Error: domain_rst_no = 0x%h, expected 0x%h", got, exp);
    fail_run();
  end
endtask

task automatic check_ack(input logic got, input logic exp);
  if (got !== exp) begin
    $display("Error: pwr_ack_o = 0x%h, expected 0x%h", got, exp);
    fail_run();
  end
endtask

`endif

/* test/tb_mcu_ctrl.sv */
// Testbench for the MCU control top level
// power command handshake, switch acknowledge model and fast interrupt checks
`default_nettype none

module tb_mcu_ctrl
  import mcu_ctrl_pkg::*;
();

  localparam int ACK_TIMEOUT = 200;

  logic                            clk_i;
  logic                            rst_i;
  logic                            debug_reset_ni;
  logic                            pwr_req_i;
  pwr_cmd_t                        pwr_cmd_i;
  logic                            pwr_ack_o;
  logic                            core_sleep_i;
  wire pwr_ctrl_in_t  [NUM_DOMAINS-1:0] pwr_ctrl_in_i;
  pwr_ctrl_out_t      [NUM_DOMAINS-1:0] pwr_ctrl_o;
  logic               [NUM_DOMAINS-1:0] domain_rst_no;
  fast_irq_src_t                   fast_src_i;
  logic                            irq_software_i;
  logic                            irq_external_i;
  logic                            irq_timer0_i;
  logic                            irq_ack_i;
  logic [IRQ_ID_W-1:0]             irq_id_i;
  logic [IRQ_W-1:0]                irq_o;

  integer        seed = 32'h4ad8d8a6;
  pwr_ctrl_out_t exp_ctrl [NUM_DOMAINS];

  mcu_ctrl_top dut0 (
    .clk_i,
    .rst_i,
    .debug_reset_ni,
    .pwr_req_i,
    .pwr_cmd_i,
    .pwr_ack_o,
    .core_sleep_i,
    .pwr_ctrl_in_i,
    .pwr_ctrl_o,
    .domain_rst_no,
    .fast_src_i,
    .irq_software_i,
    .irq_external_i,
    .irq_timer0_i,
    .irq_ack_i,
    .irq_id_i,
    .irq_o
  );

  `include "tb_mcu_ctrl_ref.svh"

  task automatic fail_run();
    $display("=== FAIL ===");
    $fatal(1, "stopped at the first failure");
  endtask

  function automatic logic [31:0] rand_word();
    return $random(seed);
  endfunction

  initial begin : clock_gen
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  // pad switch ack follows the enable after 1 to 8 cycles
  for (genvar d = 0; d < NUM_DOMAINS; d++) begin : gen_switch
    logic ack_n;
    assign pwr_ctrl_in_i[d] = '{pwrgate_ack_n: ack_n};
    initial begin : switch_model
      logic [31:0] rnd;
      ack_n = 1'b0;
      forever begin
        @(negedge clk_i);
        if (!rst_i && pwr_ctrl_o[d].pwrgate_en_n !== ack_n) begin
          rnd = rand_word();
          repeat (int'(rnd[2:0])) @(negedge clk_i);
          ack_n = pwr_ctrl_o[d].pwrgate_en_n;
        end
      end
    end
  end

  // interrupt word checked every cycle against the modeled pending bits
  initial begin : compare_irq
    logic [NUM_FAST_IRQ-1:0] pend_m;
    pend_m = '0;
    forever begin
      @(posedge clk_i);
      if (rst_i) begin
        pend_m = '0;
      end else begin
        pend_m = next_pending(pend_m, fast_src_i, irq_ack_i, irq_id_i);
      end
      #1;
      check_irq(irq_o, expected_irq(pend_m, irq_software_i, irq_timer0_i, irq_external_i));
    end
  end

  task automatic wait_ack(input logic level);
    int n;
    n = 0;
    while (pwr_ack_o !== level) begin
      @(negedge clk_i);
      n++;
      if (n > ACK_TIMEOUT) begin
        $display("timed out after %0d cycles waiting for pwr_ack_o to be %0b", n, level);
        fail_run();
      end
    end
  endtask

  task automatic check_all_ctrl();
    for (int d = 0; d < NUM_DOMAINS; d++) begin
      check_pwr_ctrl(d, pwr_ctrl_o[d], exp_ctrl[d]);
    end
  endtask

  function automatic logic [NUM_DOMAINS-1:0] expected_rst(input logic dbg_n);
    logic [NUM_DOMAINS-1:0] v;
    for (int d = 0; d < NUM_DOMAINS; d++) begin
      v[d] = exp_ctrl[d].rst_n & dbg_n;
    end
    return v;
  endfunction

  task automatic run_cmd(input int dom, input pwr_op_e op);
    @(negedge clk_i);
    pwr_cmd_i = '{domain: DOM_ID_W'(dom), op: op};
    pwr_req_i = 1'b1;
    wait_ack(1'b1);
    pwr_req_i = 1'b0;
    wait_ack(1'b0);
    if (dom < NUM_DOMAINS) begin
      exp_ctrl[dom] = next_ctrl(exp_ctrl[dom], op);
    end
    check_all_ctrl();
  endtask

  initial begin : stimulus
    logic [31:0] a;
    logic [31:0] b;
    pwr_op_e     op;
    rst_i          = 1'b1;
    debug_reset_ni = 1'b1;
    pwr_req_i      = 1'b0;
    pwr_cmd_i      = '0;
    core_sleep_i   = 1'b0;
    fast_src_i     = '0;
    irq_software_i = 1'b0;
    irq_external_i = 1'b0;
    irq_timer0_i   = 1'b0;
    irq_ack_i      = 1'b0;
    irq_id_i       = '0;
    for (int d = 0; d < NUM_DOMAINS; d++) begin
      exp_ctrl[d] = powered_state();
    end
    repeat (16) @(negedge clk_i);
    rst_i = 1'b0;

    // after reset
    @(negedge clk_i);
    check_all_ctrl();
    check_rst(domain_rst_no, {NUM_DOMAINS{1'b1}});
    check_ack(pwr_ack_o, 1'b0);

    // random commands to the non-CPU domains
    for (int i = 0; i < 40; i++) begin
      a = rand_word();
      case (a[1:0])
        2'd0:    op = PWR_ON;
        2'd1:    op = PWR_OFF;
        default: op = PWR_RETAIN;
      endcase
      run_cmd(1 + int'(a[3:2]), op);
    end

    // CPU power-down held until the core sleeps
    @(negedge clk_i);
    pwr_cmd_i = '{domain: DOM_ID_W'(DOM_CPU), op: PWR_OFF};
    pwr_req_i = 1'b1;
    repeat (50) begin
      @(negedge clk_i);
      check_ack(pwr_ack_o, 1'b0);
    end
    core_sleep_i = 1'b1;
    wait_ack(1'b1);
    pwr_req_i = 1'b0;
    wait_ack(1'b0);
    core_sleep_i = 1'b0;
    exp_ctrl[DOM_CPU] = next_ctrl(exp_ctrl[DOM_CPU], PWR_OFF);
    check_all_ctrl();
    run_cmd(DOM_CPU, PWR_ON);

    // out-of-range domains with the request held high after the ack
    for (int dom = NUM_DOMAINS; dom < 8; dom++) begin
      @(negedge clk_i);
      pwr_cmd_i = '{domain: DOM_ID_W'(dom), op: PWR_OFF};
      pwr_req_i = 1'b1;
      wait_ack(1'b1);
      repeat (10) begin
        @(negedge clk_i);
        check_ack(pwr_ack_o, 1'b1);
      end
      check_all_ctrl();
      pwr_req_i = 1'b0;
      wait_ack(1'b0);
    end

    // random interrupt traffic
    for (int i = 0; i < 300; i++) begin
      @(negedge clk_i);
      a = rand_word();
      b = rand_word();
      fast_src_i     = fast_irq_src_t'(a[15:0] & b[15:0] & a[31:16]);
      irq_software_i = b[16];
      irq_external_i = b[17];
      irq_timer0_i   = b[18];
      irq_ack_i      = b[19];
      irq_id_i       = b[24:20];
    end
    // acknowledge while dma_done is still high, then after it drops
    @(negedge clk_i);
    fast_src_i = '0;
    fast_src_i.dma_done = 1'b1;
    irq_ack_i = 1'b1;
    irq_id_i  = IRQ_ID_W'(FAST_IRQ_BASE + 3);
    repeat (2) @(negedge clk_i);
    fast_src_i = '0;
    repeat (2) @(negedge clk_i);
    irq_ack_i = 1'b0;
    irq_id_i  = '0;
    irq_software_i = 1'b0;
    irq_external_i = 1'b0;
    irq_timer0_i   = 1'b0;

    // debug reset overrides every domain reset
    @(negedge clk_i);
    debug_reset_ni = 1'b0;
    #1;
    check_rst(domain_rst_no, expected_rst(1'b0));
    repeat (3) @(negedge clk_i);
    check_all_ctrl();
    debug_reset_ni = 1'b1;
    #1;
    check_rst(domain_rst_no, expected_rst(1'b1));

    repeat (4) @(negedge clk_i);
    $display("=== PASS ===");
    $finish;
  end

endmodule

`default_nettype wire

/* hdl/mcu_ctrl_top.sv */
// MCU control top level
// domain power control with debug-qualified resets, and the core interrupt word
`default_nettype none

module mcu_ctrl_top
  import mcu_ctrl_pkg::*;
(
  input  logic                            clk_i,
  input  logic                            rst_i,
  input  logic                            debug_reset_ni,

  // power command port
  input  logic                            pwr_req_i,
  input  pwr_cmd_t                        pwr_cmd_i,
  output logic                            pwr_ack_o,
  input  logic                            core_sleep_i,

  // pad side of the domain switches
  input  pwr_ctrl_in_t  [NUM_DOMAINS-1:0] pwr_ctrl_in_i,
  output pwr_ctrl_out_t [NUM_DOMAINS-1:0] pwr_ctrl_o,
  output logic          [NUM_DOMAINS-1:0] domain_rst_no,

  // interrupts
  input  fast_irq_src_t                   fast_src_i,
  input  logic                            irq_software_i,
  input  logic                            irq_external_i,
  input  logic                            irq_timer0_i,
  input  logic                            irq_ack_i,
  input  logic          [IRQ_ID_W-1:0]    irq_id_i,
  output logic          [IRQ_W-1:0]       irq_o
);

  logic [NUM_FAST_IRQ-1:0] fast_pending;

  power_manager power_manager_i (
    .clk_i,
    .rst_i,
    .pwr_req_i,
    .pwr_cmd_i,
    .pwr_ack_o,
    .core_sleep_i,
    .ctrl_in_i(pwr_ctrl_in_i),
    .ctrl_o   (pwr_ctrl_o)
  );

  fast_irq_ctrl fast_irq_ctrl_i (
    .clk_i,
    .rst_i,
    .src_i    (fast_src_i),
    .irq_ack_i,
    .irq_id_i,
    .pending_o(fast_pending)
  );

  // domain held in reset by its sequencer or by the debug module
  for (genvar d = 0; d < NUM_DOMAINS; d++) begin : gen_dom_rst
    assign domain_rst_no[d] = pwr_ctrl_o[d].rst_n & debug_reset_ni;
  end

  always_comb begin
    irq_o                                 = '0;
    irq_o[IRQ_SOFTWARE_BIT]               = irq_software_i;
    irq_o[IRQ_TIMER_BIT]                  = irq_timer0_i;
    irq_o[IRQ_EXTERNAL_BIT]               = irq_external_i;
    irq_o[FAST_IRQ_BASE +: NUM_FAST_IRQ]  = fast_pending;
  end

endmodule

`default_nettype wire

/* hdl/fast_irq_ctrl.sv */
// Fast interrupt controller
// sticky pending bits for the fast sources, cleared by the core's acknowledge
`default_nettype none

module fast_irq_ctrl
  import mcu_ctrl_pkg::*;
(
  input  logic                    clk_i,
  input  logic                    rst_i,
  input  fast_irq_src_t           src_i,
  input  logic                    irq_ack_i,
  input  logic [IRQ_ID_W-1:0]     irq_id_i,
  output logic [NUM_FAST_IRQ-1:0] pending_o
);

  logic [NUM_FAST_IRQ-1:0] pending_q;
  logic [NUM_FAST_IRQ-1:0] set_mask;
  logic [NUM_FAST_IRQ-1:0] clr_mask;
  logic                    ack_fast;
  logic [FAST_IDX_W-1:0]   ack_idx;

  assign set_mask = src_i;

  // ids from the fast base upwards belong to this block
  assign ack_fast = irq_ack_i && (irq_id_i >= IRQ_ID_W'(FAST_IRQ_BASE));
  assign ack_idx  = FAST_IDX_W'(irq_id_i - IRQ_ID_W'(FAST_IRQ_BASE));

  always_comb begin
    clr_mask = '0;
    if (ack_fast) begin
      clr_mask[ack_idx] = 1'b1;
    end
  end

  // a source still high wins over the clear
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      pending_q <= '0;
    end else begin
      pending_q <= (pending_q & ~clr_mask) | set_mask;
    end
  end

  assign pending_o = pending_q;

endmodule

`default_nettype wire

/* hdl/power_manager.sv */
// Power manager
// takes req/ack power commands and runs one sequencer per domain,
// holding CPU power-down until the core sleeps
`default_nettype none

module power_manager
  import mcu_ctrl_pkg::*;
(
  input  logic                            clk_i,
  input  logic                            rst_i,
  input  logic                            pwr_req_i,
  input  pwr_cmd_t                        pwr_cmd_i,
  output logic                            pwr_ack_o,
  input  logic                            core_sleep_i,
  input  pwr_ctrl_in_t  [NUM_DOMAINS-1:0] ctrl_in_i,
  output pwr_ctrl_out_t [NUM_DOMAINS-1:0] ctrl_o
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_WAIT_SLEEP,
    ST_BUSY,
    ST_ACK
  } hs_state_e;

  hs_state_e              state_q;
  pwr_cmd_t               cmd_q;
  logic                   dom_valid;
  logic                   sleep_ok;
  logic                   start;
  logic [NUM_DOMAINS-1:0] done_vec;

  assign dom_valid = (int'(cmd_q.domain) < NUM_DOMAINS);

  // only powering the CPU up is allowed while it is awake
  assign sleep_ok = core_sleep_i || (cmd_q.op == PWR_ON) ||
                    (cmd_q.domain != DOM_ID_W'(DOM_CPU));

  assign start     = (state_q == ST_WAIT_SLEEP) && dom_valid && sleep_ok;
  assign pwr_ack_o = (state_q == ST_ACK);

  always_ff @(posedge clk_i) begin
    if (state_q == ST_IDLE && pwr_req_i) begin
      cmd_q <= pwr_cmd_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q <= ST_IDLE;
    end else begin
      case (state_q)
        ST_IDLE: if (pwr_req_i) state_q <= ST_WAIT_SLEEP;
        ST_WAIT_SLEEP: begin
          if (!dom_valid) begin
            state_q <= ST_ACK;
          end else if (sleep_ok) begin
            state_q <= ST_BUSY;
          end
        end
        // only the started sequencer can report done
        ST_BUSY: if (|done_vec) state_q <= ST_ACK;
        ST_ACK:  if (!pwr_req_i) state_q <= ST_IDLE;
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  for (genvar d = 0; d < NUM_DOMAINS; d++) begin : gen_dom
    power_domain_fsm power_domain_fsm_i (
      .clk_i,
      .rst_i,
      .start_i  (start && (cmd_q.domain == DOM_ID_W'(d))),
      .op_i     (cmd_q.op),
      .ctrl_in_i(ctrl_in_i[d]),
      .ctrl_o   (ctrl_o[d]),
      .done_o   (done_vec[d])
    );
  end

endmodule

`default_nettype wire

/* hdl/power_domain_fsm.sv */
// Power domain sequencer
// steps one domain's switch, isolation, reset, clock gate and retention
// controls, one change per clock, and waits on the switch acknowledge
`default_nettype none

module power_domain_fsm
  import mcu_ctrl_pkg::*;
(
  input  logic          clk_i,
  input  logic          rst_i,
  input  logic          start_i,
  input  pwr_op_e       op_i,
  input  pwr_ctrl_in_t  ctrl_in_i,
  output pwr_ctrl_out_t ctrl_o,
  output logic          done_o
);

  typedef enum logic [3:0] {
    S_ON,
    S_OFF,
    S_RET,
    S_OFF_ISO,
    S_OFF_RST,
    S_OFF_SW,
    S_OFF_WAIT,
    S_ON_WAIT,
    S_ON_ISO,
    S_ON_CLK,
    S_ON_RET,
    S_RET_RET
  } state_e;

  state_e        state_q;
  pwr_ctrl_out_t ctrl_q;
  logic          done_q;
  logic          sw_settled;

  // pad ack follows the switch enable once the rail has settled
  assign sw_settled = (ctrl_in_i.pwrgate_ack_n == ctrl_q.pwrgate_en_n);

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q <= S_ON;
      ctrl_q  <= PWR_CTRL_RESET;
      done_q  <= 1'b0;
    end else begin
      done_q <= 1'b0;
      case (state_q)
        S_ON: begin
          if (start_i) begin
            case (op_i)
              PWR_OFF: begin
                ctrl_q.clkgate_en_n <= 1'b0;
                state_q             <= S_OFF_ISO;
              end
              PWR_RETAIN: begin
                ctrl_q.clkgate_en_n <= 1'b0;
                state_q             <= S_RET_RET;
              end
              default: done_q <= 1'b1;
            endcase
          end
        end
        S_OFF: begin
          if (start_i) begin
            if (op_i == PWR_ON) begin
              ctrl_q.pwrgate_en_n <= 1'b0;
              state_q             <= S_ON_WAIT;
            end else begin
              // already off, nothing to retain
              done_q <= 1'b1;
            end
          end
        end
        S_RET: begin
          if (start_i) begin
            case (op_i)
              PWR_ON: begin
                // switch is already closed, wait falls through
                ctrl_q.pwrgate_en_n <= 1'b0;
                state_q             <= S_ON_WAIT;
              end
              PWR_OFF: begin
                ctrl_q.clkgate_en_n <= 1'b0;
                state_q             <= S_OFF_ISO;
              end
              default: done_q <= 1'b1;
            endcase
          end
        end
        S_OFF_ISO: begin
          ctrl_q.isogate_en_n <= 1'b0;
          state_q             <= S_OFF_RST;
        end
        S_OFF_RST: begin
          ctrl_q.rst_n <= 1'b0;
          state_q      <= S_OFF_SW;
        end
        S_OFF_SW: begin
          ctrl_q.pwrgate_en_n <= 1'b1;
          state_q             <= S_OFF_WAIT;
        end
        S_OFF_WAIT: begin
          if (sw_settled) begin
            done_q  <= 1'b1;
            state_q <= S_OFF;
          end
        end
        S_ON_WAIT: begin
          if (sw_settled) begin
            ctrl_q.rst_n <= 1'b1;
            state_q      <= S_ON_ISO;
          end
        end
        S_ON_ISO: begin
          ctrl_q.isogate_en_n <= 1'b1;
          state_q             <= S_ON_CLK;
        end
        S_ON_CLK: begin
          ctrl_q.clkgate_en_n <= 1'b1;
          state_q             <= S_ON_RET;
        end
        S_ON_RET: begin
          ctrl_q.retentive_en_n <= 1'b1;
          done_q                <= 1'b1;
          state_q               <= S_ON;
        end
        S_RET_RET: begin
          ctrl_q.retentive_en_n <= 1'b0;
          done_q                <= 1'b1;
          state_q               <= S_RET;
        end
        default: state_q <= S_ON;
      endcase
    end
  end

  assign ctrl_o = ctrl_q;
  assign done_o = done_q;

endmodule

`default_nettype wire

/* hdl/mcu_ctrl_pkg.sv */
// MCU control package
// domain indices, power command and control types, fast interrupt layout
`default_nettype none

package mcu_ctrl_pkg;

  // switchable domains
  localparam int DOM_CPU    = 0;
  localparam int DOM_PERIPH = 1;
  localparam int DOM_MEM0   = 2;
  localparam int DOM_MEM1   = 3;
  localparam int DOM_EXT0   = 4;

  localparam int NUM_DOMAINS = DOM_EXT0 + 1;
  localparam int DOM_ID_W    = 3;

  // core interrupt word
  localparam int IRQ_W            = 32;
  localparam int IRQ_ID_W         = 5;
  localparam int IRQ_SOFTWARE_BIT = 3;
  localparam int IRQ_TIMER_BIT    = 7;
  localparam int IRQ_EXTERNAL_BIT = 11;

  localparam int NUM_FAST_IRQ  = 16;
  localparam int FAST_IRQ_BASE = 16;
  localparam int FAST_IDX_W    = $clog2(NUM_FAST_IRQ);

  typedef enum logic [1:0] {
    PWR_ON     = 2'd0,
    PWR_OFF    = 2'd1,
    PWR_RETAIN = 2'd2
  } pwr_op_e;

  typedef struct packed {
    logic [DOM_ID_W-1:0] domain;
    pwr_op_e             op;
  } pwr_cmd_t;

  // all controls active low
  typedef struct packed {
    logic pwrgate_en_n;
    logic isogate_en_n;
    logic rst_n;
    logic clkgate_en_n;
    logic retentive_en_n;
  } pwr_ctrl_out_t;

  typedef struct packed {
    logic pwrgate_ack_n;
  } pwr_ctrl_in_t;

  // powered and running
  localparam pwr_ctrl_out_t PWR_CTRL_RESET = '{
    pwrgate_en_n:   1'b0,
    isogate_en_n:   1'b1,
    rst_n:          1'b1,
    clkgate_en_n:   1'b1,
    retentive_en_n: 1'b1
  };

  // msb first, timer1 sits at bit 0
  typedef struct packed {
    logic       ext_peripheral;
    logic       dma_window;
    logic [7:0] gpio_ao;
    logic       spi_flash;
    logic       spi;
    logic       dma_done;
    logic       timer3;
    logic       timer2;
    logic       timer1;
  } fast_irq_src_t;

endpackage

`default_nettype wire
